// ==== design/qmem_bank_if.sv ====
// Bank write and bank read interfaces
// between the writer, the reader and the page banks

// Write side, one strobe per stored word
interface qmem_bank_wr_if #(
    parameter int ADDR_W = 7
);
    logic               en;
    logic [ADDR_W-1:0]  addr;
    qmem_pkg::data_t    data;
    qmem_pkg::blen_t    blen;

    modport writer (
        output en,
        output addr,
        output data,
        output blen
    );

    modport bank (
        input  en,
        input  addr,
        input  data,
        input  blen
    );
endinterface

// Read side, data returns the cycle after en
interface qmem_bank_rd_if #(
    parameter int ADDR_W = 7
);
    logic               en;
    logic [ADDR_W-1:0]  addr;
    qmem_pkg::data_t    rd_data;
    qmem_pkg::blen_t    rd_blen;

    modport reader (
        output en,
        output addr,
        input  rd_data,
        input  rd_blen
    );

    modport bank (
        input  en,
        input  addr,
        output rd_data,
        output rd_blen
    );
endinterface

// ==== design/qmem_dequeue_reader.sv ====
// Dequeue reader: request routing to banks, read collection,
// output word, dequeue notification and page-free pulse
module qmem_dequeue_reader #(
    parameter int NUM_PAGES      = 32,
    parameter int WORDS_PER_PAGE = 16,
    parameter int NUM_BANKS      = 4
) (
    input  logic                    packet_in,
    input  logic                    rst_n,
    input  logic                    deq_valid,
    input  qmem_pkg::queue_id_t     deq_queue,
    input  qmem_pkg::page_ptr_t     deq_page,
    input  qmem_pkg::word_ptr_t     deq_head,
    qmem_bank_rd_if.reader          rd [NUM_BANKS],
    output logic                    out_valid,
    output qmem_pkg::data_t         out_data,
    output qmem_pkg::keep_t         out_keep,
    output logic                    out_last,
    output qmem_pkg::egress_port_t  out_port,
    output logic                    notify_valid,
    output qmem_pkg::valid_bytes_t  notify_bytes,
    output qmem_pkg::queue_id_t     notify_queue,
    output logic                    notify_last,
    output logic                    free_valid,
    output qmem_pkg::page_ptr_t     free_page
);

    localparam int PAGE_W = $clog2(NUM_PAGES);
    localparam int WORD_W = $clog2(WORDS_PER_PAGE);
    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int ADDR_W = PAGE_W - BANK_W + WORD_W;
    localparam int QW     = qmem_pkg::QUEUE_ID_W;
    localparam int EW     = qmem_pkg::EGR_PORT_W;

    logic [BANK_W-1:0]    bank_sel;
    logic [NUM_BANKS-1:0] rd_en_q;
    logic [ADDR_W-1:0]    rd_addr_q;

    // Request context, two deep to match the bank latency
    logic                 s1_valid;
    qmem_pkg::queue_id_t  s1_queue;
    logic [BANK_W-1:0]    s1_bank;
    logic                 s1_free;
    qmem_pkg::page_ptr_t  s1_page;
    logic                 s2_valid;
    qmem_pkg::queue_id_t  s2_queue;
    logic [BANK_W-1:0]    s2_bank;
    logic                 s2_free;
    qmem_pkg::page_ptr_t  s2_page;

    qmem_pkg::data_t      bank_data [NUM_BANKS];
    qmem_pkg::blen_t      bank_blen [NUM_BANKS];
    qmem_pkg::blen_t      sel_blen;
    qmem_pkg::keep_enc_t  sel_enc;

    //////////////////////////////////////////////////
    // Request stage

    assign bank_sel = deq_page[BANK_W-1:0];

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            rd_en_q  <= '0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                rd_en_q[b] <= deq_valid && (bank_sel == BANK_W'(b));
            end
            s1_valid <= deq_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge packet_in) begin
        rd_addr_q <= {deq_page[PAGE_W-1:BANK_W], deq_head[WORD_W-1:0]};
        s1_queue  <= deq_queue;
        s1_bank   <= bank_sel;
        s1_free   <= (deq_head == qmem_pkg::word_ptr_t'(WORDS_PER_PAGE - 1));
        s1_page   <= deq_page;
        s2_queue  <= s1_queue;
        s2_bank   <= s1_bank;
        s2_free   <= s1_free;
        s2_page   <= s1_page;
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_rd
        assign rd[b].en      = rd_en_q[b];
        assign rd[b].addr    = rd_addr_q;
        assign bank_data[b]  = rd[b].rd_data;
        assign bank_blen[b]  = rd[b].rd_blen;
    end

    //////////////////////////////////////////////////
    // Output stage

    assign sel_blen = bank_blen[s2_bank];
    assign sel_enc  = sel_blen[qmem_pkg::KEEP_ENC_W:1];

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            notify_valid <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            out_valid    <= s2_valid;
            notify_valid <= s2_valid;
            free_valid   <= s2_valid && s2_free;
        end
    end

    always_ff @(posedge packet_in) begin
        out_data     <= bank_data[s2_bank];
        out_keep     <= qmem_pkg::decode_keep(sel_enc);
        out_last     <= sel_blen[0];
        out_port     <= s2_queue[QW-1:QW-EW];
        notify_bytes <= qmem_pkg::keep_enc_to_valid_bytes(sel_enc);
        notify_queue <= s2_queue;
        notify_last  <= sel_blen[0];
        free_page    <= s2_page;
    end

    // Requests must address a real page and word
    a_head_range: assert property (
        @(posedge packet_in) disable iff (!rst_n)
        deq_valid |-> int'(deq_head) < WORDS_PER_PAGE
    );

    a_page_range: assert property (
        @(posedge packet_in) disable iff (!rst_n)
        deq_valid |-> int'(deq_page) < NUM_PAGES
    );

endmodule

// ==== design/qmem_enqueue_writer.sv ====
// Enqueue writer: page and word address tracking,
// mask encoding and write steering to the page banks
module qmem_enqueue_writer #(
    parameter int NUM_PAGES      = 32,
    parameter int WORDS_PER_PAGE = 16,
    parameter int NUM_BANKS      = 4
) (
    input  logic                  packet_in,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  qmem_pkg::data_t       in_data,
    input  qmem_pkg::keep_t       in_keep,
    input  logic                  in_last,
    input  qmem_pkg::page_ptr_t   in_cur_page,
    input  qmem_pkg::page_ptr_t   in_next_page,
    input  qmem_pkg::word_ptr_t   in_tail,
    qmem_bank_wr_if.writer        wr [NUM_BANKS]
);

    localparam int PAGE_W = $clog2(NUM_PAGES);
    localparam int WORD_W = $clog2(WORDS_PER_PAGE);
    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int ADDR_W = PAGE_W - BANK_W + WORD_W;

    // Packet tracking state
    logic                 sop;
    logic [WORD_W-1:0]    word_idx;
    logic [PAGE_W-1:0]    cur_page;
    logic [PAGE_W-1:0]    next_page;

    // Address of the word on the input this cycle
    logic [WORD_W-1:0]    word_sel;
    logic [PAGE_W-1:0]    page_sel;
    logic [PAGE_W-1:0]    next_sel;
    logic [BANK_W-1:0]    bank_sel;
    logic                 page_end;

    logic [NUM_BANKS-1:0] wr_en_q;
    logic [ADDR_W-1:0]    wr_addr_q;
    qmem_pkg::data_t      wr_data_q;
    qmem_pkg::blen_t      wr_blen_q;

    //////////////////////////////////////////////////
    // Address tracking

    // First word takes its address from the metadata
    assign word_sel = sop ? in_tail[WORD_W-1:0] : word_idx;
    assign page_sel = sop ? in_cur_page[PAGE_W-1:0] : cur_page;
    assign next_sel = sop ? in_next_page[PAGE_W-1:0] : next_page;
    assign bank_sel = page_sel[BANK_W-1:0];
    assign page_end = (word_sel == WORD_W'(WORDS_PER_PAGE - 1));

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            sop       <= 1'b1;
            word_idx  <= '0;
            cur_page  <= '0;
            next_page <= '0;
        end else if (in_valid) begin
            sop       <= in_last;
            next_page <= next_sel;
            // Cross into the saved next page at the boundary
            if (page_end) begin
                word_idx <= '0;
                cur_page <= next_sel;
            end else begin
                word_idx <= word_sel + 1'b1;
                cur_page <= page_sel;
            end
        end
    end

    //////////////////////////////////////////////////
    // Write stage

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            wr_en_q <= '0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                wr_en_q[b] <= in_valid && (bank_sel == BANK_W'(b));
            end
        end
    end

    // Low page bits pick the bank, the rest is the bank-local page
    always_ff @(posedge packet_in) begin
        if (in_valid) begin
            wr_addr_q <= {page_sel[PAGE_W-1:BANK_W], word_sel};
            wr_data_q <= in_data;
            wr_blen_q <= {qmem_pkg::encode_keep(in_keep), in_last};
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_wr
        assign wr[b].en   = wr_en_q[b];
        assign wr[b].addr = wr_addr_q;
        assign wr[b].data = wr_data_q;
        assign wr[b].blen = wr_blen_q;
    end

    // An all-zero mask has no encoding
    a_keep_nonzero: assert property (
        @(posedge packet_in) disable iff (!rst_n)
        in_valid |-> in_keep != '0
    );

endmodule

// ==== design/qmem_page_bank.sv ====
// One page bank: word storage and length storage
// with a write port and a registered read port
module qmem_page_bank #(
    parameter int DEPTH = 128
) (
    input  logic          packet_in,
    input  logic          rst_n,
    qmem_bank_wr_if.bank  wr,
    qmem_bank_rd_if.bank  rd
);

    //////////////////////////////////////////////////
    // Storage

    qmem_pkg::data_t word_mem [DEPTH];
    qmem_pkg::blen_t blen_mem [DEPTH];

    // Word and length entry are always written together
    always_ff @(posedge packet_in) begin
        if (wr.en) begin
            word_mem[wr.addr] <= wr.data;
            blen_mem[wr.addr] <= wr.blen;
        end
    end

    //////////////////////////////////////////////////
    // Read port

    // Holds the last read until the next enable
    always_ff @(posedge packet_in) begin
        if (rd.en) begin
            rd.rd_data <= word_mem[rd.addr];
            rd.rd_blen <= blen_mem[rd.addr];
        end
    end

    //////////////////////////////////////////////////
    // Checks

    a_wr_addr_range: assert property (
        @(posedge packet_in) disable iff (!rst_n)
        wr.en |-> int'(wr.addr) < DEPTH
    );

    a_rd_addr_range: assert property (
        @(posedge packet_in) disable iff (!rst_n)
        rd.en |-> int'(rd.addr) < DEPTH
    );

endmodule

// ==== design/qmem_pkg.sv ====
// Queue memory widths, typed vectors and
// byte-enable mask encode and decode functions
package qmem_pkg;

    //////////////////////////////////////////////////
    // Widths

    localparam int DATA_BYTES          = 8;
    localparam int KEEP_ENC_W          = 3;
    localparam int QUEUES_PER_EGR_PORT = 4;
    localparam int QUEUE_ID_W          = 4;
    localparam int PAGE_PTR_W          = 8;
    localparam int WORD_PTR_W          = 8;
    // Egress port is the upper part of the queue id
    localparam int EGR_PORT_W          = QUEUE_ID_W - $clog2(QUEUES_PER_EGR_PORT);

    //////////////////////////////////////////////////
    // Typed vectors

    typedef logic [DATA_BYTES*8-1:0]  data_t;
    typedef logic [DATA_BYTES-1:0]    keep_t;
    typedef logic [KEEP_ENC_W-1:0]    keep_enc_t;
    // Encoded mask in the upper bits, last flag in bit 0
    typedef logic [KEEP_ENC_W:0]      blen_t;
    typedef logic [KEEP_ENC_W:0]      valid_bytes_t;
    typedef logic [PAGE_PTR_W-1:0]    page_ptr_t;
    typedef logic [WORD_PTR_W-1:0]    word_ptr_t;
    typedef logic [QUEUE_ID_W-1:0]    queue_id_t;
    typedef logic [EGR_PORT_W-1:0]    egress_port_t;

    //////////////////////////////////////////////////
    // Mask coding

    // Full mask maps to 0, else the first clear bit above bit 0
    function automatic keep_enc_t encode_keep(input keep_t keep);
        keep_enc_t code;
        logic      found;
        code  = '0;
        found = 1'b0;
        for (int i = 1; i < DATA_BYTES; i++) begin
            if (!found && !keep[i]) begin
                code  = KEEP_ENC_W'(i);
                found = 1'b1;
            end
        end
        return code;
    endfunction

    function automatic keep_t decode_keep(input keep_enc_t code);
        keep_t keep;
        keep = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (code == '0 || i < int'(code)) begin
                keep[i] = 1'b1;
            end
        end
        return keep;
    endfunction

    function automatic valid_bytes_t keep_enc_to_valid_bytes(input keep_enc_t code);
        return (code == '0) ? valid_bytes_t'(DATA_BYTES) : {1'b0, code};
    endfunction

endpackage

// ==== design/queue_memory_top.sv ====
// Queue memory top level: enqueue writer, banked
// page storage and dequeue reader
module queue_memory_top #(
    parameter int NUM_PAGES      = 32,
    parameter int WORDS_PER_PAGE = 16,
    parameter int NUM_BANKS      = 4
) (
    input  logic                    packet_in,
    input  logic                    rst_n,
    // Enqueue side
    input  logic                    in_valid,
    input  qmem_pkg::data_t         in_data,
    input  qmem_pkg::keep_t         in_keep,
    input  logic                    in_last,
    input  qmem_pkg::page_ptr_t     in_cur_page,
    input  qmem_pkg::page_ptr_t     in_next_page,
    input  qmem_pkg::word_ptr_t     in_tail,
    // Dequeue requests
    input  logic                    deq_valid,
    input  qmem_pkg::queue_id_t     deq_queue,
    input  qmem_pkg::page_ptr_t     deq_page,
    input  qmem_pkg::word_ptr_t     deq_head,
    // Dequeued words, notification, page free
    output logic                    out_valid,
    output qmem_pkg::data_t         out_data,
    output qmem_pkg::keep_t         out_keep,
    output logic                    out_last,
    output qmem_pkg::egress_port_t  out_port,
    output logic                    notify_valid,
    output qmem_pkg::valid_bytes_t  notify_bytes,
    output qmem_pkg::queue_id_t     notify_queue,
    output logic                    notify_last,
    output logic                    free_valid,
    output qmem_pkg::page_ptr_t     free_page
);

    // Words held by each bank
    localparam int DEPTH  = NUM_PAGES / NUM_BANKS * WORDS_PER_PAGE;
    localparam int ADDR_W = $clog2(DEPTH);

    //////////////////////////////////////////////////
    // Bank interfaces

    qmem_bank_wr_if #(.ADDR_W(ADDR_W)) wr_if [NUM_BANKS] ();
    qmem_bank_rd_if #(.ADDR_W(ADDR_W)) rd_if [NUM_BANKS] ();

    //////////////////////////////////////////////////
    // Datapath

    qmem_enqueue_writer #(
        .NUM_PAGES      (NUM_PAGES),
        .WORDS_PER_PAGE (WORDS_PER_PAGE),
        .NUM_BANKS      (NUM_BANKS)
    ) u_writer (
        .packet_in    (packet_in),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_keep      (in_keep),
        .in_last      (in_last),
        .in_cur_page  (in_cur_page),
        .in_next_page (in_next_page),
        .in_tail      (in_tail),
        .wr           (wr_if)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        qmem_page_bank #(
            .DEPTH (DEPTH)
        ) u_bank (
            .packet_in (packet_in),
            .rst_n     (rst_n),
            .wr        (wr_if[b]),
            .rd        (rd_if[b])
        );
    end

    qmem_dequeue_reader #(
        .NUM_PAGES      (NUM_PAGES),
        .WORDS_PER_PAGE (WORDS_PER_PAGE),
        .NUM_BANKS      (NUM_BANKS)
    ) u_reader (
        .packet_in    (packet_in),
        .rst_n        (rst_n),
        .deq_valid    (deq_valid),
        .deq_queue    (deq_queue),
        .deq_page     (deq_page),
        .deq_head     (deq_head),
        .rd           (rd_if),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .out_last     (out_last),
        .out_port     (out_port),
        .notify_valid (notify_valid),
        .notify_bytes (notify_bytes),
        .notify_queue (notify_queue),
        .notify_last  (notify_last),
        .free_valid   (free_valid),
        .free_page    (free_page)
    );

endmodule

// ==== files.f ====
design/qmem_pkg.sv
design/qmem_bank_if.sv
design/qmem_enqueue_writer.sv
design/qmem_page_bank.sv
design/qmem_dequeue_reader.sv
design/queue_memory_top.sv
test/tb_queue_memory.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the queue memory testbench with Verilator, run it, then check the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_queue_memory -f files.f &&
    ./obj_dir/Vtb_queue_memory 2>&1 | tee sim.log

[ -f sim.log ] && ! grep -q "STATUS: FAIL" sim.log && grep -q "STATUS: PASS" sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

// ==== test/tb_queue_memory.sv ====
// Queue memory testbench with packet writes, dequeue requests,
// reference model and per-cycle output compare
module tb_queue_memory;

    localparam int NUM_PAGES      = 32;
    localparam int WORDS_PER_PAGE = 16;
    localparam int NUM_BANKS      = 4;
    localparam int CYCLE_LIMIT    = 3000;

    // Expected outputs of one dequeue request
    typedef struct packed {
        int                     due;
        qmem_pkg::data_t        data;
        qmem_pkg::keep_t        keep;
        logic                   last;
        qmem_pkg::valid_bytes_t bytes;
        qmem_pkg::queue_id_t    queue;
        qmem_pkg::egress_port_t port;
        logic                   free;
        qmem_pkg::page_ptr_t    page;
    } exp_t;

    logic                   packet_in;
    logic                   rst_n;
    logic                   in_valid;
    qmem_pkg::data_t        in_data;
    qmem_pkg::keep_t        in_keep;
    logic                   in_last;
    qmem_pkg::page_ptr_t    in_cur_page;
    qmem_pkg::page_ptr_t    in_next_page;
    qmem_pkg::word_ptr_t    in_tail;
    logic                   deq_valid;
    qmem_pkg::queue_id_t    deq_queue;
    qmem_pkg::page_ptr_t    deq_page;
    qmem_pkg::word_ptr_t    deq_head;
    logic                   out_valid;
    qmem_pkg::data_t        out_data;
    qmem_pkg::keep_t        out_keep;
    logic                   out_last;
    qmem_pkg::egress_port_t out_port;
    logic                   notify_valid;
    qmem_pkg::valid_bytes_t notify_bytes;
    qmem_pkg::queue_id_t    notify_queue;
    logic                   notify_last;
    logic                   free_valid;
    qmem_pkg::page_ptr_t    free_page;

    int   cycle = 0;
    exp_t exp_q [$];

    // Reference memory keyed by page * WORDS_PER_PAGE + word
    qmem_pkg::data_t ref_data [int];
    qmem_pkg::keep_t ref_keep [int];
    logic            ref_last [int];

    queue_memory_top #(
        .NUM_PAGES      (NUM_PAGES),
        .WORDS_PER_PAGE (WORDS_PER_PAGE),
        .NUM_BANKS      (NUM_BANKS)
    ) DUT (.*);

    initial packet_in = 1'b0;
    always #20 packet_in = ~packet_in;

    //////////////////////////////////////////////////
    // Error reporting and compare tasks

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input qmem_pkg::data_t exp_data, input qmem_pkg::keep_t exp_keep,
                              input logic exp_last);
        if (out_data !== exp_data)
            stop_on_error($sformatf("Mismatch at %0t: out_data %h, expected %h",
                                    $time, out_data, exp_data));
        if (out_keep !== exp_keep)
            stop_on_error($sformatf("Mismatch at %0t: out_keep %h, expected %h",
                                    $time, out_keep, exp_keep));
        if (out_last !== exp_last)
            stop_on_error($sformatf("Mismatch at %0t: out_last %b, expected %b",
                                    $time, out_last, exp_last));
    endtask

    task automatic check_port(input qmem_pkg::egress_port_t exp_port);
        if (out_port !== exp_port)
            stop_on_error($sformatf("Mismatch at %0t: out_port %0d, expected %0d",
                                    $time, out_port, exp_port));
    endtask

    task automatic check_notify(input qmem_pkg::valid_bytes_t exp_bytes,
                                input qmem_pkg::queue_id_t exp_queue, input logic exp_last);
        if (notify_bytes !== exp_bytes)
            stop_on_error($sformatf("Mismatch at %0t: notify_bytes %0d, expected %0d",
                                    $time, notify_bytes, exp_bytes));
        if (notify_queue !== exp_queue)
            stop_on_error($sformatf("Mismatch at %0t: notify_queue %0d, expected %0d",
                                    $time, notify_queue, exp_queue));
        if (notify_last !== exp_last)
            stop_on_error($sformatf("Mismatch at %0t: notify_last %b, expected %b",
                                    $time, notify_last, exp_last));
    endtask

    task automatic check_free(input qmem_pkg::page_ptr_t exp_page);
        if (free_page !== exp_page)
            stop_on_error($sformatf("Mismatch at %0t: free_page %0d, expected %0d",
                                    $time, free_page, exp_page));
    endtask

    //////////////////////////////////////////////////
    // Reference model

    // Valid bytes fill the mask from bit 0 upward
    function automatic qmem_pkg::keep_t low_mask(input int n);
        return qmem_pkg::keep_t'((9'd1 << n) - 9'd1);
    endfunction

    function automatic exp_t ref_read(input int queue, input int page, input int head,
                                      input int due);
        exp_t e;
        int   key;
        key     = page * WORDS_PER_PAGE + head;
        e.due   = due;
        e.data  = ref_data[key];
        e.keep  = ref_keep[key];
        e.last  = ref_last[key];
        e.bytes = qmem_pkg::valid_bytes_t'($countones(ref_keep[key]));
        e.queue = qmem_pkg::queue_id_t'(queue);
        e.port  = qmem_pkg::egress_port_t'(queue / qmem_pkg::QUEUES_PER_EGR_PORT);
        e.free  = (head == WORDS_PER_PAGE - 1);
        e.page  = qmem_pkg::page_ptr_t'(page);
        return e;
    endfunction

    // Cycle count and run limit
    always @(posedge packet_in) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT)
            stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", cycle));
    end

    // Outputs are settled at the falling edge
    always @(negedge packet_in) begin : compare_outputs
        exp_t e;
        if (rst_n) begin
            if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                e = exp_q.pop_front();
                if (out_valid !== 1'b1 || notify_valid !== 1'b1)
                    stop_on_error($sformatf("Missing output or notify pulse at time %0t", $time));
                check_word(e.data, e.keep, e.last);
                check_port(e.port);
                check_notify(e.bytes, e.queue, e.last);
                if (e.free) begin
                    if (free_valid !== 1'b1)
                        stop_on_error($sformatf("Missing page-free pulse at time %0t", $time));
                    check_free(e.page);
                end else if (free_valid !== 1'b0) begin
                    stop_on_error($sformatf("Unexpected page-free pulse at time %0t", $time));
                end
            end else if (out_valid !== 1'b0 || notify_valid !== 1'b0 || free_valid !== 1'b0) begin
                stop_on_error($sformatf("Unexpected output pulse at time %0t", $time));
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic step_cycle();
        @(posedge packet_in);
        #5;
    endtask

    task automatic write_packet(input int cur_page, input int next_page, input int tail,
                                input int len, input int last_bytes);
        int page;
        int word;
        page = cur_page;
        word = tail;
        for (int i = 0; i < len; i++) begin
            in_valid     = 1'b1;
            in_data      = {$urandom, $urandom};
            in_keep      = (i == len - 1) ? low_mask(last_bytes) : '1;
            in_last      = (i == len - 1);
            in_cur_page  = qmem_pkg::page_ptr_t'(cur_page);
            in_next_page = qmem_pkg::page_ptr_t'(next_page);
            in_tail      = qmem_pkg::word_ptr_t'(tail);
            ref_data[page * WORDS_PER_PAGE + word] = in_data;
            ref_keep[page * WORDS_PER_PAGE + word] = in_keep;
            ref_last[page * WORDS_PER_PAGE + word] = in_last;
            // Wrap into the saved next page
            if (word == WORDS_PER_PAGE - 1) begin
                word = 0;
                page = next_page;
            end else begin
                word++;
            end
            step_cycle();
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic request(input int queue, input int page, input int head);
        deq_valid = 1'b1;
        deq_queue = qmem_pkg::queue_id_t'(queue);
        deq_page  = qmem_pkg::page_ptr_t'(page);
        deq_head  = qmem_pkg::word_ptr_t'(head);
        exp_q.push_back(ref_read(queue, page, head, cycle + 3));
        step_cycle();
    endtask

    task automatic read_page(input int page);
        int gap;
        for (int w = 0; w < WORDS_PER_PAGE; w++) begin
            if (ref_data.exists(page * WORDS_PER_PAGE + w)) begin
                request($urandom_range(0, 15), page, w);
                gap = $urandom_range(0, 2);
                if (gap > 0) begin
                    deq_valid = 1'b0;
                    repeat (gap) step_cycle();
                end
            end
        end
    endtask

    // One request per cycle with banks taken in turn
    task automatic burst_requests(input int count);
        int page;
        int word;
        for (int i = 0; i < count; i++) begin
            do begin
                page = i % NUM_BANKS + NUM_BANKS * $urandom_range(0, NUM_PAGES / NUM_BANKS - 1);
                word = $urandom_range(0, WORDS_PER_PAGE - 1);
            end while (!ref_data.exists(page * WORDS_PER_PAGE + word));
            request($urandom_range(0, 15), page, word);
        end
    endtask

    task automatic drain_requests();
        deq_valid = 1'b0;
        while (exp_q.size() != 0)
            step_cycle();
        step_cycle();
    endtask

    initial begin
        int tail;
        int len;
        void'($urandom(79));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_keep      = '1;
        in_last      = 1'b0;
        in_cur_page  = '0;
        in_next_page = '0;
        in_tail      = '0;
        // Requests held during reset must not reach the outputs
        deq_valid    = 1'b1;
        deq_queue    = '0;
        deq_page     = '0;
        deq_head     = '0;
        repeat (10) @(posedge packet_in);
        #5;
        rst_n     = 1'b1;
        deq_valid = 1'b0;
        @(posedge packet_in);
        @(negedge packet_in);
        if (out_valid !== 1'b0 || notify_valid !== 1'b0 || free_valid !== 1'b0)
            stop_on_error("Output pulses are not low in the first cycle after reset");
        step_cycle();

        // Single-page packets with pages 0 and 5 filled completely
        for (int p = 0; p < 8; p++) begin
            tail = (p == 0 || p == 5) ? 0 : $urandom_range(0, 8);
            len  = (p == 0 || p == 5) ? WORDS_PER_PAGE : $urandom_range(1, WORDS_PER_PAGE - tail);
            write_packet(p, p + 8, tail, len, $urandom_range(1, 8));
        end
        step_cycle();
        for (int p = 0; p < 8; p++)
            read_page(p);
        drain_requests();

        // Packets that cross into their next page
        write_packet(20, 11, 13, 8, 5);
        write_packet(26, 9, 15, 3, 8);
        step_cycle();
        read_page(20);
        read_page(11);
        read_page(26);
        read_page(9);
        drain_requests();

        burst_requests(120);
        drain_requests();

        $display("STATUS: PASS");
        $finish;
    end

endmodule
